//--- Bender.yml
package:
  name: rvExecute

export_include_dirs:
  - verilog

sources:
  - files:
      - verilog/executePkg.sv
      - verilog/mulUnitIf.sv
      - verilog/pipeReg.sv
      - verilog/aluUnit.sv
      - verilog/mulUnit.sv
      - verilog/executeControl.sv
      - verilog/executeStage.sv
  - target: test
    files:
      - testbench/executeStageTb.sv

//--- rvExecute.f
+incdir+verilog
verilog/executePkg.sv
verilog/mulUnitIf.sv
verilog/pipeReg.sv
verilog/aluUnit.sv
verilog/mulUnit.sv
verilog/executeControl.sv
verilog/executeStage.sv
testbench/executeStageTb.sv

//--- testbench/executeStageTb.sv
// Random-stimulus testbench for the execute stage, checks every result against a reference model.
`timescale 1ns/1ps
`default_nettype none

module executeStageTb;

    import executePkg::*;

    localparam int NUM_OPS        = 400;
    localparam int RESET_CYCLES   = 8;
    localparam int TIMEOUT_CYCLES = NUM_OPS * 40 + RESET_CYCLES;
    localparam logic [31:0] SEED  = 32'd60783;
    localparam logic [31:0] SIGN  = 32'h8000_0000;

    logic       clk;
    logic       rstN;
    logic       inValid;
    logic       inReady;
    execOpT     inOp;
    logic       outValid;
    logic       outReady;
    execResultT outResult;

    logic [31:0] rngState;
    execResultT  expected[$];
    int          accepted;
    int          checked = 0;
    int          cycleCount = 0;

    // two-stage tracker for the fixed alu/trap latency
    logic latencyArm1 = 1'b0;
    logic latencyArm2 = 1'b0;
    wordT latencyPc1  = '0;
    wordT latencyPc2  = '0;

    executeStage UUT (
        .clk       (clk),
        .rstN      (rstN),
        .inValid   (inValid),
        .inReady   (inReady),
        .inOp      (inOp),
        .outValid  (outValid),
        .outReady  (outReady),
        .outResult (outResult)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] randWord();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    task automatic abortRun();
        $display("Testbench failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
        $display("[ERROR] %s got 0x%08h expected 0x%08h", name, got, exp);
        abortRun();
    endtask

    task automatic checkField(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else reportMismatch(name, got, exp);
    endtask

    task automatic compareResult(input execResultT got, input execResultT exp);
        checkField("outResult.pc", got.pc, exp.pc);
        checkField("outResult.dstValue", got.dstValue, exp.dstValue);
        checkField("outResult.branchTaken", 32'(got.branchTaken), 32'(exp.branchTaken));
        checkField("outResult.nextPc", got.nextPc, exp.nextPc);
        checkField("outResult.trapValid", 32'(got.trapValid), 32'(exp.trapValid));
        checkField("outResult.trapCause", 32'(got.trapCause), 32'(exp.trapCause));
    endtask

    task automatic checkIdle();
        checkField("outValid", 32'(outValid), 32'd0);
        checkField("inReady", 32'(inReady), 32'd1);
        checkField("mul.start", 32'(UUT.mulLink.start), 32'd0);
        checkField("mul.done", 32'(UUT.mulLink.done), 32'd0);
    endtask

    function automatic execOpT makeOp();
        execOpT      o;
        logic [31:0] pick;
        pick         = randWord();
        o.pc         = randWord() & 32'hFFFF_FFFC;
        o.rs1Value   = randWord();
        // equal operands now and then so eq/ne branches go both ways
        o.rs2Value   = (pick[3:2] == 2'd0) ? o.rs1Value : randWord();
        o.imm        = randWord();
        o.aluCmd     = aluCmdT'(4'(randWord() % 32'd12));
        o.branchType = branchTypeT'(3'(randWord() % 32'd7));
        o.src1Sel    = src1SelT'(2'(randWord() % 32'd3));
        o.src2Sel    = src2SelT'(2'(randWord() % 32'd3));
        o.wbSel      = wbSelT'(pick[4]);
        o.mulCmd     = mulCmdT'(pick[5]);
        o.trapOp     = trapOpT'(pick[6]);
        o.isBranch   = pick[7];
        o.unit       = UnitAlu;
        if (pick[10:8] == 3'd0 || pick[10:8] == 3'd1) begin
            o.unit = (pick[8]) ? UnitTrap : UnitMul;
            o.isBranch = 1'b0;
            o.wbSel = WbResult;
        end
        return o;
    endfunction

    // reference model of one operation
    function automatic execResultT predict(input execOpT o);
        execResultT  r;
        wordT        a;
        wordT        b;
        wordT        alu;
        logic [4:0]  sh;
        logic [63:0] prod;
        logic        take;
        wordT        link;
        a = (o.src1Sel == Src1Pc) ? o.pc : (o.src1Sel == Src1Reg) ? o.rs1Value : 32'd0;
        b = (o.src2Sel == Src2Imm) ? o.imm : (o.src2Sel == Src2Reg) ? o.rs2Value : 32'd0;
        sh = b[4:0];
        case (o.aluCmd)
            AluAdd:    alu = a + b;
            AluSub:    alu = a + ~b + 32'd1;
            AluSll:    alu = a << sh;
            AluSlt:    alu = {31'd0, (a ^ SIGN) < (b ^ SIGN)};
            AluSltu:   alu = {31'd0, a < b};
            AluXor:    alu = a ^ b;
            AluSrl:    alu = a >> sh;
            AluSra:    alu = 32'({{32{a[31]}}, a} >> sh);
            AluOr:     alu = a | b;
            AluAnd:    alu = a & b;
            AluClear1: alu = a & ~b;
            AluClear2: alu = ~a & b;
            default:   alu = 32'd0;
        endcase
        case (o.branchType)
            BranchEqual:                take = o.rs1Value == o.rs2Value;
            BranchNotEqual:             take = o.rs1Value != o.rs2Value;
            BranchLessThan:             take = (o.rs1Value ^ SIGN) < (o.rs2Value ^ SIGN);
            BranchGreaterEqual:         take = !((o.rs1Value ^ SIGN) < (o.rs2Value ^ SIGN));
            BranchUnsignedLessThan:     take = o.rs1Value < o.rs2Value;
            BranchUnsignedGreaterEqual: take = !(o.rs1Value < o.rs2Value);
            default:                    take = 1'b1;
        endcase
        take = o.isBranch && take;
        link = o.pc + 32'd4;
        prod = {32'd0, o.rs1Value} * {32'd0, o.rs2Value};
        r.pc          = o.pc;
        r.branchTaken = take;
        r.nextPc      = take ? alu : link;
        r.trapValid   = 1'b0;
        r.trapCause   = trapCauseT'(5'd0);
        if (o.unit == UnitTrap) begin
            r.dstValue  = 32'd0;
            r.trapValid = 1'b1;
            // ecall from machine mode is 11, breakpoint is 3
            r.trapCause = trapCauseT'((o.trapOp == TrapEcall) ? 5'd11 : 5'd3);
        end else if (o.wbSel == WbNextPc) begin
            r.dstValue = link;
        end else if (o.unit == UnitMul) begin
            r.dstValue = (o.mulCmd == MulLow) ? prod[31:0] : prod[63:32];
        end else begin
            r.dstValue = alu;
        end
        return r;
    endfunction

    // pop on output transfer, then push on input transfer
    always @(posedge clk) begin
        if (rstN) begin
            if (latencyArm2) begin
                assert (outValid && outResult.pc == latencyPc2) else begin
                    $display("alu or trap result did not appear two cycles after its input");
                    abortRun();
                end
            end
            latencyArm2 = latencyArm1 && outReady;
            latencyPc2  = latencyPc1;
            latencyArm1 = inValid && inReady && (inOp.unit != UnitMul);
            latencyPc1  = inOp.pc;
            if (outValid && outReady) begin
                if (expected.size() == 0) begin
                    $display("output transfer with no operation outstanding");
                    abortRun();
                end else begin
                    compareResult(outResult, expected.pop_front());
                    checked++;
                end
            end
            if (inValid && inReady) begin
                expected.push_back(predict(inOp));
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > TIMEOUT_CYCLES) begin
            $display("timeout, only %0d of %0d results arrived", checked, NUM_OPS);
            abortRun();
        end
    end

    initial begin
        rngState = SEED;
        rstN     = 1'b0;
        inValid  = 1'b0;
        inOp     = '0;
        outReady = 1'b0;
        accepted = 0;

        repeat (RESET_CYCLES) begin
            @(negedge clk);
            checkIdle();
        end
        @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        checkIdle();

        while (accepted < NUM_OPS) begin
            @(posedge clk);
            if (inValid && inReady) begin
                accepted++;
            end
            // about 30 percent back-pressure
            outReady <= (randWord() % 32'd10) >= 32'd3;
            if (!inValid || inReady) begin
                if (accepted < NUM_OPS && (randWord() & 32'd3) != 32'd0) begin
                    inValid <= 1'b1;
                    inOp    <= makeOp();
                end else begin
                    inValid <= 1'b0;
                end
            end
        end

        // drain the remaining results
        while (checked < NUM_OPS) begin
            @(posedge clk);
            outReady <= (randWord() % 32'd10) >= 32'd3;
            @(negedge clk);
        end
        @(posedge clk);
        outReady <= 1'b1;
        repeat (4) begin
            @(negedge clk);
            checkField("outValid", 32'(outValid), 32'd0);
        end

        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/aluUnit.sv
// Combinational operand selection, integer ALU and branch comparator of the execute stage.
`timescale 1ns/1ps
`default_nettype none

`include "execute_params.svh"

module aluUnit (
    input  executePkg::execOpT op,
    output executePkg::wordT   aluResult,
    output logic               branchTaken
);

    import executePkg::*;

    wordT                  src1;
    wordT                  src2;
    logic [`XLEN_LOG2-1:0] shamt;
    logic                  compare;

    always_comb begin
        unique case (op.src1Sel)
            Src1Zero: src1 = '0;
            Src1Pc:   src1 = op.pc;
            Src1Reg:  src1 = op.rs1Value;
            default:  src1 = '0;
        endcase

        unique case (op.src2Sel)
            Src2Zero: src2 = '0;
            Src2Imm:  src2 = op.imm;
            Src2Reg:  src2 = op.rs2Value;
            default:  src2 = '0;
        endcase
    end

    assign shamt = src2[`XLEN_LOG2-1:0];

    always_comb begin
        unique case (op.aluCmd)
            AluAdd:    aluResult = src1 + src2;
            AluSub:    aluResult = src1 - src2;
            AluSll:    aluResult = src1 << shamt;
            AluSlt:    aluResult = wordT'($signed(src1) < $signed(src2));
            AluSltu:   aluResult = wordT'(src1 < src2);
            AluXor:    aluResult = src1 ^ src2;
            AluSrl:    aluResult = src1 >> shamt;
            AluSra:    aluResult = $signed(src1) >>> shamt;
            AluOr:     aluResult = src1 | src2;
            AluAnd:    aluResult = src1 & src2;
            AluClear1: aluResult = src1 & ~src2;
            AluClear2: aluResult = ~src1 & src2;
            default:   aluResult = '0;
        endcase
    end

    // comparator works on the register values, not the ALU operands
    always_comb begin
        unique case (op.branchType)
            BranchEqual:                compare = op.rs1Value == op.rs2Value;
            BranchNotEqual:             compare = op.rs1Value != op.rs2Value;
            BranchLessThan:             compare = $signed(op.rs1Value) < $signed(op.rs2Value);
            BranchGreaterEqual:         compare = $signed(op.rs1Value) >= $signed(op.rs2Value);
            BranchUnsignedLessThan:     compare = op.rs1Value < op.rs2Value;
            BranchUnsignedGreaterEqual: compare = op.rs1Value >= op.rs2Value;
            BranchAlways:               compare = 1'b1;
            default:                    compare = 1'b0;
        endcase
    end

    assign branchTaken = op.isBranch && compare;

endmodule

`default_nettype wire

//--- verilog/executeControl.sv
// Execute stage controller that tracks completion, builds the result record and hands it onward.
`timescale 1ns/1ps
`default_nettype none

`include "execute_params.svh"

module executeControl (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   opValid,
    input  executePkg::execOpT     op,
    output logic                   opPop,
    input  executePkg::wordT       aluResult,
    input  logic                   branchTaken,
    mulUnitIf.ctrl                 mul,
    output logic                   resValid,
    input  logic                   resReady,
    output executePkg::execResultT result
);

    import executePkg::*;

    logic mulStarted;
    logic mulFinished;
    wordT productReg;

    logic isMul;
    logic finished;
    wordT mulValue;
    wordT unitValue;
    wordT pcNext;

    assign isMul = opValid && (op.unit == UnitMul);

    // one start per held operation
    assign mul.start = isMul && !mulStarted && !mul.busy;
    assign mul.cmd   = op.mulCmd;
    assign mul.src1  = op.rs1Value;
    assign mul.src2  = op.rs2Value;

    // alu and trap finish in the cycle they are held
    assign finished = (op.unit != UnitMul) || mulFinished || mul.done;
    assign resValid = opValid && finished;
    assign opPop    = resValid && resReady;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            mulStarted  <= 1'b0;
            mulFinished <= 1'b0;
        end else if (opPop) begin
            mulStarted  <= 1'b0;
            mulFinished <= 1'b0;
        end else begin
            if (mul.start) begin
                mulStarted <= 1'b1;
            end
            if (mul.done) begin
                mulFinished <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mul.done) begin
            productReg <= mul.product;
        end
    end

    assign mulValue  = mul.done ? mul.product : productReg;
    assign unitValue = (op.unit == UnitMul) ? mulValue : aluResult;
    assign pcNext    = op.pc + `XLEN'(`INSN_SIZE);

    always_comb begin
        result.pc          = op.pc;
        result.branchTaken = branchTaken;
        result.nextPc      = branchTaken ? aluResult : pcNext;
        result.trapValid   = 1'b0;
        result.trapCause   = trapCauseT'('0);

        if (op.unit == UnitTrap) begin
            result.dstValue  = '0;
            result.trapValid = 1'b1;
            // always machine mode
            result.trapCause = (op.trapOp == TrapEcall) ? CauseEcallFromMachine
                                                        : CauseBreakpoint;
        end else if (op.wbSel == WbNextPc) begin
            result.dstValue = pcNext;
        end else begin
            result.dstValue = unitValue;
        end
    end

endmodule

`default_nettype wire

//--- verilog/executePkg.sv
// Types shared by the execute stage RTL and its testbench: commands, records and trap causes.
`default_nettype none

package executePkg;

    `include "execute_params.svh"

    typedef logic [`XLEN-1:0] wordT;

    typedef enum logic [1:0] {
        UnitAlu,
        UnitMul,
        UnitTrap
    } unitT;

    typedef enum logic [3:0] {
        AluAdd,
        AluSub,
        AluSll,
        AluSlt,
        AluSltu,
        AluXor,
        AluSrl,
        AluSra,
        AluOr,
        AluAnd,
        AluClear1,
        AluClear2
    } aluCmdT;

    typedef enum logic [2:0] {
        BranchEqual,
        BranchNotEqual,
        BranchLessThan,
        BranchGreaterEqual,
        BranchUnsignedLessThan,
        BranchUnsignedGreaterEqual,
        BranchAlways
    } branchTypeT;

    typedef enum logic [1:0] {
        Src1Zero,
        Src1Pc,
        Src1Reg
    } src1SelT;

    typedef enum logic [1:0] {
        Src2Zero,
        Src2Imm,
        Src2Reg
    } src2SelT;

    typedef enum logic {
        WbResult,
        WbNextPc
    } wbSelT;

    typedef enum logic {
        MulLow,
        MulHighUnsigned
    } mulCmdT;

    typedef enum logic {
        TrapEcall,
        TrapEbreak
    } trapOpT;

    // machine-mode exception codes
    typedef enum logic [4:0] {
        CauseBreakpoint       = 5'd3,
        CauseEcallFromMachine = 5'd11
    } trapCauseT;

    typedef struct packed {
        unitT       unit;
        aluCmdT     aluCmd;
        logic       isBranch;
        branchTypeT branchType;
        src1SelT    src1Sel;
        src2SelT    src2Sel;
        wbSelT      wbSel;
        mulCmdT     mulCmd;
        trapOpT     trapOp;
        wordT       pc;
        wordT       rs1Value;
        wordT       rs2Value;
        wordT       imm;
    } execOpT;

    typedef struct packed {
        wordT      pc;
        wordT      dstValue;
        logic      branchTaken;
        wordT      nextPc;
        logic      trapValid;
        trapCauseT trapCause;
    } execResultT;

endpackage

`default_nettype wire

//--- verilog/executeStage.sv
// Top level of the integer execute stage with valid/ready input and output.
`timescale 1ns/1ps
`default_nettype none

module executeStage (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   inValid,
    output logic                   inReady,
    input  executePkg::execOpT     inOp,
    output logic                   outValid,
    input  logic                   outReady,
    output executePkg::execResultT outResult
);

    import executePkg::*;

    logic       opValid;
    execOpT     op;
    logic       opPop;
    wordT       aluResult;
    logic       branchTaken;
    logic       resValid;
    logic       resReady;
    execResultT result;

    mulUnitIf mulLink ();

    pipeReg #(
        .payloadT(execOpT)
    ) inReg (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (inValid),
        .inReady  (inReady),
        .inData   (inOp),
        .outValid (opValid),
        .outReady (opPop),
        .outData  (op)
    );

    aluUnit alu (
        .op          (op),
        .aluResult   (aluResult),
        .branchTaken (branchTaken)
    );

    mulUnit multiplier (
        .clk  (clk),
        .rstN (rstN),
        .mul  (mulLink.unit)
    );

    executeControl control (
        .clk         (clk),
        .rstN        (rstN),
        .opValid     (opValid),
        .op          (op),
        .opPop       (opPop),
        .aluResult   (aluResult),
        .branchTaken (branchTaken),
        .mul         (mulLink.ctrl),
        .resValid    (resValid),
        .resReady    (resReady),
        .result      (result)
    );

    pipeReg #(
        .payloadT(execResultT)
    ) outReg (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (resValid),
        .inReady  (resReady),
        .inData   (result),
        .outValid (outValid),
        .outReady (outReady),
        .outData  (outResult)
    );

endmodule

`default_nettype wire

//--- verilog/execute_params.svh
// Width and size macros for the execute stage, included by the package and the RTL.
`ifndef EXECUTE_PARAMS_SVH
`define EXECUTE_PARAMS_SVH

// data path word width
`define XLEN 32

// shift amount width for the low five bits of RV32
`define XLEN_LOG2 5

// pc step of one instruction in bytes
`define INSN_SIZE 4

// multiplier step counter wide enough to count XLEN steps
`define MUL_COUNT_WIDTH 6

`endif

//--- verilog/mulUnit.sv
// Iterative shift-add unsigned multiplier, one bit per cycle, giving the low or high word.
`timescale 1ns/1ps
`default_nettype none

`include "execute_params.svh"

module mulUnit (
    input logic    clk,
    input logic    rstN,
    mulUnitIf.unit mul
);

    import executePkg::*;

    logic                        busy;
    logic                        done;
    logic [`MUL_COUNT_WIDTH-1:0] count;
    logic [2*`XLEN-1:0]          acc;
    wordT                        mcand;
    mulCmdT                      cmdReg;

    logic [2*`XLEN-1:0] accIn;
    wordT               mcandIn;
    logic [`XLEN:0]     partial;
    logic [2*`XLEN-1:0] accNext;

    // the start cycle already performs the first step on the incoming sources
    assign accIn   = busy ? acc : {{`XLEN{1'b0}}, mul.src2};
    assign mcandIn = busy ? mcand : mul.src1;

    // add multiplicand into the upper half when the low bit is set, then shift right
    assign partial = {1'b0, accIn[2*`XLEN-1:`XLEN]} + (accIn[0] ? {1'b0, mcandIn} : '0);
    assign accNext = {partial, accIn[`XLEN-1:1]};

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            busy  <= 1'b0;
            done  <= 1'b0;
            count <= '0;
        end else begin
            done <= 1'b0;
            if (mul.start) begin
                busy  <= 1'b1;
                count <= `MUL_COUNT_WIDTH'(1);
            end else if (busy) begin
                count <= count + 1'b1;
                // last step lands this edge
                if (count == `MUL_COUNT_WIDTH'(`XLEN - 1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mul.start || busy) begin
            acc <= accNext;
        end
        if (mul.start) begin
            mcand  <= mul.src1;
            cmdReg <= mul.cmd;
        end
    end

    assign mul.busy    = busy;
    assign mul.done    = done;
    assign mul.product = (cmdReg == MulLow) ? acc[`XLEN-1:0] : acc[2*`XLEN-1:`XLEN];

endmodule

`default_nettype wire

//--- verilog/mulUnitIf.sv
// Start/done link between the execute controller and the iterative multiplier.
`timescale 1ns/1ps
`default_nettype none

interface mulUnitIf;

    import executePkg::*;

    logic   start;
    logic   busy;
    mulCmdT cmd;
    wordT   src1;
    wordT   src2;
    logic   done;
    wordT   product;

    modport ctrl (
        output start, cmd, src1, src2,
        input  busy, done, product
    );

    modport unit (
        input  start, cmd, src1, src2,
        output busy, done, product
    );

endinterface

`default_nettype wire

//--- verilog/pipeReg.sv
// Single-entry valid/ready holding register for any payload type, used at stage boundaries.
`timescale 1ns/1ps
`default_nettype none

module pipeReg #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    rstN,
    input  logic    inValid,
    output logic    inReady,
    input  payloadT inData,
    output logic    outValid,
    input  logic    outReady,
    output payloadT outData
);

    logic    full;
    payloadT data;

    // accept when empty or when the held entry leaves this cycle
    assign inReady  = !full || outReady;
    assign outValid = full;
    assign outData  = data;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            full <= 1'b0;
        end else if (inValid && inReady) begin
            full <= 1'b1;
        end else if (outReady) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (inValid && inReady) begin
            data <= inData;
        end
    end

endmodule

`default_nettype wire
